/* include/tlb_defs.svh */
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// ==================================================
// tlb geometry
// ==================================================

// number of ways, the last one holds boot and pinned entries
`define TLB_WAYS 4
`define TLB_SETS 64        // sets per way
`define TLB_IDX_W 6        // low bits of the vpn pick the set

// ==================================================
// boot mapping, identity mapped at the top of memory
// ==================================================

`define TLB_BOOT_VPN 20'hFFFF0   // first boot page
`define TLB_BOOT_PAGES 16        // must not exceed TLB_SETS

`endif

/* source/tlb_pkg.sv */
package tlb_pkg;

	// ==================================================
	// ram entry, msb first
	// ==================================================
	typedef struct packed {
		logic        v;     // valid
		logic        g;     // global, ignores asid
		logic [7:0]  asid;
		logic [19:0] vpn;
		logic [19:0] ppn;
		logic        a;     // accessed
		logic        d;     // dirty
		logic        c;     // user rights
		logic        r;
		logic        w;
		logic        x;
		logic        sc;    // system rights
		logic        sr;
		logic        sw;
		logic        sx;
	} tlb_entry_t;

	// reset-time fill sequence
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_RUN,
		FILL_DONE
	} fill_state_t;

	// register block select, REG_MODE is {xlat_en, sys}
	typedef enum logic {
		REG_ASID,
		REG_MODE
	} reg_sel_t;

	// access kind on the lookup port
	typedef enum logic [1:0] {
		ACC_LOAD,
		ACC_STORE,
		ACC_FETCH
	} acc_kind_t;

endpackage

/* source/tlb_way_ram.sv */
`timescale 1ns/1ps
`include "tlb_defs.svh"

module tlb_way_ram (
	input  logic                  clk_g,
	// port A, shared by fill, write-back and software
	input  logic                  a_en_i,
	input  logic                  a_we_i,
	input  logic [`TLB_IDX_W-1:0] a_idx_i,
	input  tlb_pkg::tlb_entry_t   a_din_i,
	output tlb_pkg::tlb_entry_t   a_dout_o,
	// port B, lookup reads only
	input  logic [`TLB_IDX_W-1:0] b_idx_i,
	output tlb_pkg::tlb_entry_t   b_dout_o
);
	import tlb_pkg::*;

	tlb_entry_t mem [`TLB_SETS];   // cleared by the boot fill

	// port A: write plus read-first registered output
	always_ff @(posedge clk_g) begin
		if (a_en_i) begin
			if (a_we_i) begin
				mem[a_idx_i] <= a_din_i;
			end
			a_dout_o <= mem[a_idx_i];   // old data on a write cycle
		end
	end

	// port B: registered read every cycle
	always_ff @(posedge clk_g) begin
		b_dout_o <= mem[b_idx_i];
	end

endmodule

/* source/tlb_boot_fill.sv */
`timescale 1ns/1ps
`include "tlb_defs.svh"

module tlb_boot_fill (
	input  logic                  clk_g,
	input  logic                  rst_i,
	output logic                  fill_we_o,
	output logic [`TLB_IDX_W-1:0] fill_idx_o,
	output logic [`TLB_WAYS-1:0]  fill_way_mask_o,
	output tlb_pkg::tlb_entry_t   fill_data_o [`TLB_WAYS],
	output logic                  rdy_o
);
	import tlb_pkg::*;

	localparam logic [19:0] BOOT_VPN = `TLB_BOOT_VPN;

	fill_state_t           state;
	logic [`TLB_IDX_W-1:0] set_cnt;    // set being written
	logic [19:0]           boot_vpn;   // boot page that would land in this set
	logic                  in_boot;
	tlb_entry_t            boot_ent;

	// ==================================================
	// sequencer, one set per cycle
	// ==================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			state   <= FILL_IDLE;
			set_cnt <= '0;
		end else begin
			case (state)
				FILL_IDLE: state <= FILL_RUN;   // first edge after reset
				FILL_RUN: begin
					set_cnt <= set_cnt + 1'b1;   // wraps back to 0 at the end
					if (set_cnt == `TLB_IDX_W'(`TLB_SETS - 1))
						state <= FILL_DONE;
				end
				default: state <= FILL_DONE;   // stays here until reset
			endcase
		end
	end

	// identity entry for the boot window, global with every right
	assign boot_vpn = {BOOT_VPN[19:`TLB_IDX_W], set_cnt};
	assign in_boot  = (boot_vpn - BOOT_VPN) < 20'(`TLB_BOOT_PAGES);

	always_comb begin
		boot_ent      = '1;          // v, g, a, d and all rights set
		boot_ent.asid = 8'h00;
		boot_ent.vpn  = boot_vpn;
		boot_ent.ppn  = boot_vpn;    // identity mapping
	end

	// every way written together, only the last one gets boot entries
	always_comb begin
		for (int w = 0; w < `TLB_WAYS; w++) begin
			fill_data_o[w] = '0;     // invalid
			if (w == `TLB_WAYS - 1 && in_boot)
				fill_data_o[w] = boot_ent;
		end
	end

	assign fill_we_o       = (state == FILL_RUN);
	assign fill_idx_o      = set_cnt;
	assign fill_way_mask_o = {`TLB_WAYS{fill_we_o}};
	assign rdy_o           = (state == FILL_DONE);

endmodule

/* source/tlb_ctrl_regs.sv */
`timescale 1ns/1ps
`include "tlb_defs.svh"

module tlb_ctrl_regs (
	input  logic                         clk_g,
	input  logic                         rst_i,
	// register port
	input  logic                         reg_we_i,
	input  tlb_pkg::reg_sel_t            reg_sel_i,
	input  logic [7:0]                   reg_wdata_i,
	// software entry write, holds the victim counter
	input  logic                         tlb_wr_i,
	output logic [7:0]                   asid_o,
	output logic                         sys_mode_o,
	output logic                         xlat_en_o,
	output logic [$clog2(`TLB_WAYS)-1:0] victim_way_o
);
	import tlb_pkg::*;

	localparam int WAY_W = $clog2(`TLB_WAYS);
	localparam logic [WAY_W-1:0] VICTIM_LAST = WAY_W'(`TLB_WAYS - 2);

	// ==================================================
	// asid and mode
	// ==================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			asid_o     <= 8'h00;
			sys_mode_o <= 1'b0;    // user
			xlat_en_o  <= 1'b0;    // translation off, addresses pass through
		end else if (reg_we_i) begin
			case (reg_sel_i)
				REG_ASID: asid_o <= reg_wdata_i;
				REG_MODE: begin
					sys_mode_o <= reg_wdata_i[0];
					xlat_en_o  <= reg_wdata_i[1];
				end
				default: ;
			endcase
		end
	end

	// ==================================================
	// victim way for random writes
	// ==================================================
	// free-running, stops while software writes so the chosen way is stable
	// never reaches the last way, that one is kept for boot and pinned pages
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			victim_way_o <= '0;
		end else if (!tlb_wr_i) begin
			if (victim_way_o == VICTIM_LAST)
				victim_way_o <= '0;
			else
				victim_way_o <= victim_way_o + 1'b1;
		end
	end

endmodule

/* source/tlb_lookup.sv */
`timescale 1ns/1ps
`include "tlb_defs.svh"

module tlb_lookup (
	input  logic                         clk_g,
	input  logic                         rst_i,
	// access request
	input  logic                         acc_i,
	input  logic [31:0]                  vadr_i,
	input  tlb_pkg::acc_kind_t           kind_i,
	// mode from the register block
	input  logic [7:0]                   asid_i,
	input  logic                         sys_mode_i,
	input  logic                         xlat_en_i,
	// port B data of every way
	input  tlb_pkg::tlb_entry_t          way_dout_i [`TLB_WAYS],
	output logic [`TLB_IDX_W-1:0]        idx_o,
	// results
	output logic                         done_o,
	output logic [31:0]                  padr_o,
	output logic [3:0]                   acr_o,
	output logic                         miss_o,
	output logic [31:0]                  miss_adr_o,
	// accessed / dirty write-back onto port A
	output logic                         wb_we_o,
	output logic [`TLB_IDX_W-1:0]        wb_idx_o,
	output logic [$clog2(`TLB_WAYS)-1:0] wb_way_o,
	output tlb_pkg::tlb_entry_t          wb_data_o
);
	import tlb_pkg::*;

	localparam int WAY_W = $clog2(`TLB_WAYS);

	// stage 1 request
	logic        s1_vld;
	logic [31:0] s1_vadr;
	acc_kind_t   s1_kind;
	logic [7:0]  s1_asid;
	logic        s1_sys;
	logic        s1_xlat;

	// stage 2 compare
	logic             hit;
	logic [WAY_W-1:0] hit_way;
	tlb_entry_t       hit_ent;
	tlb_entry_t       wb_ent;
	logic             is_store;
	logic             need_wb;

	// index goes to port B in the same cycle as the strobe
	assign idx_o = vadr_i[12 +: `TLB_IDX_W];

	// ==================================================
	// stage 1, capture request and mode
	// ==================================================
	always_ff @(posedge clk_g) begin
		if (rst_i)
			s1_vld <= 1'b0;
		else
			s1_vld <= acc_i;
	end

	always_ff @(posedge clk_g) begin
		if (acc_i) begin
			s1_vadr <= vadr_i;
			s1_kind <= kind_i;
			s1_asid <= asid_i;      // mode sampled with the request
			s1_sys  <= sys_mode_i;
			s1_xlat <= xlat_en_i;
		end
	end

	// ==================================================
	// stage 2, compare every way
	// ==================================================
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		hit_ent = '0;
		// walk downward so the lowest matching way wins
		for (int w = `TLB_WAYS - 1; w >= 0; w--) begin
			if (way_dout_i[w].v && way_dout_i[w].vpn == s1_vadr[31:12] &&
			    (way_dout_i[w].g || way_dout_i[w].asid == s1_asid)) begin
				hit     = 1'b1;
				hit_way = WAY_W'(w);
				hit_ent = way_dout_i[w];
			end
		end
	end

	assign is_store = (s1_kind == ACC_STORE);
	// write back only when a or d actually changes
	assign need_wb = s1_vld && s1_xlat && hit &&
	                 (!hit_ent.a || (is_store && !hit_ent.d));

	always_comb begin
		wb_ent   = hit_ent;
		wb_ent.a = 1'b1;
		if (is_store)
			wb_ent.d = 1'b1;   // loads and fetches leave d alone
	end

	// result registers
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			done_o <= 1'b0;
			miss_o <= 1'b0;
			padr_o <= 32'h0;
			acr_o  <= 4'h0;
		end else begin
			done_o <= s1_vld;
			miss_o <= 1'b0;                          // strobe, one cycle only
			if (s1_vld) begin
				if (!s1_xlat) begin
					padr_o <= s1_vadr;                   // pass-through
					acr_o  <= 4'hF;
				end else if (hit) begin
					padr_o <= {hit_ent.ppn, s1_vadr[11:0]};
					acr_o  <= s1_sys ? {hit_ent.sc, hit_ent.sr, hit_ent.sw, hit_ent.sx}
					                 : {hit_ent.c, hit_ent.r, hit_ent.w, hit_ent.x};
				end else begin
					padr_o <= 32'h0;
					acr_o  <= 4'h0;
					miss_o <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_g) begin
		if (s1_vld && s1_xlat && !hit)
			miss_adr_o <= s1_vadr;   // faulting address for the handler
	end

	// write-back request, lands on port A one edge later
	always_ff @(posedge clk_g) begin
		if (rst_i)
			wb_we_o <= 1'b0;
		else
			wb_we_o <= need_wb;
	end

	always_ff @(posedge clk_g) begin
		if (need_wb) begin
			wb_idx_o  <= s1_vadr[12 +: `TLB_IDX_W];
			wb_way_o  <= hit_way;
			wb_data_o <= wb_ent;
		end
	end

endmodule

/* source/tlb_top.sv */
`timescale 1ns/1ps
`include "tlb_defs.svh"

module tlb_top (
	input  logic                         clk_g,
	input  logic                         rst_i,
	output logic                         rdy_o,
	// access port
	input  logic                         acc_i,
	input  logic [31:0]                  vadr_i,
	input  tlb_pkg::acc_kind_t           kind_i,
	output logic                         done_o,
	output logic [31:0]                  padr_o,
	output logic [3:0]                   acr_o,
	output logic                         miss_o,
	output logic [31:0]                  miss_adr_o,
	// software entry port
	input  logic                         tlb_wr_i,
	input  logic                         tlb_rd_i,
	input  logic [`TLB_IDX_W-1:0]        tlb_idx_i,
	input  logic [$clog2(`TLB_WAYS)-1:0] tlb_way_i,
	input  logic                         tlb_rand_i,
	input  tlb_pkg::tlb_entry_t          tlb_wdata_i,
	output tlb_pkg::tlb_entry_t          tlb_rdata_o,
	output logic                         rd_done_o,
	// register port
	input  logic                         reg_we_i,
	input  tlb_pkg::reg_sel_t            reg_sel_i,
	input  logic [7:0]                   reg_wdata_i
);
	import tlb_pkg::*;

	localparam int WAY_W = $clog2(`TLB_WAYS);

	// fill
	logic                  fill_we;
	logic [`TLB_IDX_W-1:0] fill_idx;
	logic [`TLB_WAYS-1:0]  fill_mask;
	tlb_entry_t            fill_data [`TLB_WAYS];
	// registers
	logic [7:0]       asid;
	logic             sys_mode;
	logic             xlat_en;
	logic [WAY_W-1:0] victim_way;
	// lookup
	logic [`TLB_IDX_W-1:0] lk_idx;
	logic                  wb_we;
	logic [`TLB_IDX_W-1:0] wb_idx;
	logic [WAY_W-1:0]      wb_way;
	tlb_entry_t            wb_data;
	// ram ports
	logic                  a_en;
	logic [`TLB_IDX_W-1:0] a_idx;
	logic                  a_we   [`TLB_WAYS];
	tlb_entry_t            a_din  [`TLB_WAYS];
	tlb_entry_t            a_dout [`TLB_WAYS];
	tlb_entry_t            b_dout [`TLB_WAYS];
	// software
	logic [WAY_W-1:0] wr_way;
	logic             rd_q;      // read issued, ram output valid next cycle
	logic [WAY_W-1:0] rd_way_q;

	tlb_boot_fill u_fill (
		.clk_g           (clk_g),
		.rst_i           (rst_i),
		.fill_we_o       (fill_we),
		.fill_idx_o      (fill_idx),
		.fill_way_mask_o (fill_mask),
		.fill_data_o     (fill_data),
		.rdy_o           (rdy_o)
	);

	tlb_ctrl_regs u_regs (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.reg_we_i     (reg_we_i),
		.reg_sel_i    (reg_sel_i),
		.reg_wdata_i  (reg_wdata_i),
		.tlb_wr_i     (tlb_wr_i),
		.asid_o       (asid),
		.sys_mode_o   (sys_mode),
		.xlat_en_o    (xlat_en),
		.victim_way_o (victim_way)
	);

	tlb_lookup u_lookup (
		.clk_g      (clk_g),
		.rst_i      (rst_i),
		.acc_i      (acc_i),
		.vadr_i     (vadr_i),
		.kind_i     (kind_i),
		.asid_i     (asid),
		.sys_mode_i (sys_mode),
		.xlat_en_i  (xlat_en),
		.way_dout_i (b_dout),
		.idx_o      (lk_idx),
		.done_o     (done_o),
		.padr_o     (padr_o),
		.acr_o      (acr_o),
		.miss_o     (miss_o),
		.miss_adr_o (miss_adr_o),
		.wb_we_o    (wb_we),
		.wb_idx_o   (wb_idx),
		.wb_way_o   (wb_way),
		.wb_data_o  (wb_data)
	);

	// ==================================================
	// port A arbitration: fill, then write-back, then software
	// ==================================================
	assign wr_way = tlb_rand_i ? victim_way : tlb_way_i;   // random never hits last way
	assign a_en   = fill_we | wb_we | tlb_wr_i | tlb_rd_i;
	assign a_idx  = fill_we ? fill_idx : wb_we ? wb_idx : tlb_idx_i;

	for (genvar w = 0; w < `TLB_WAYS; w++) begin : g_way
		assign a_we[w] = fill_we ? fill_mask[w] :
		                 wb_we   ? (wb_way == WAY_W'(w)) :
		                           (tlb_wr_i && wr_way == WAY_W'(w));
		assign a_din[w] = fill_we ? fill_data[w] : wb_we ? wb_data : tlb_wdata_i;

		tlb_way_ram u_ram (
			.clk_g    (clk_g),
			.a_en_i   (a_en),
			.a_we_i   (a_we[w]),
			.a_idx_i  (a_idx),
			.a_din_i  (a_din[w]),
			.a_dout_o (a_dout[w]),
			.b_idx_i  (lk_idx),
			.b_dout_o (b_dout[w])
		);
	end

	// ==================================================
	// software read-back, two edges to rd_done_o
	// ==================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			rd_q      <= 1'b0;
			rd_done_o <= 1'b0;
		end else begin
			rd_q      <= tlb_rd_i;
			rd_done_o <= rd_q;
		end
	end

	always_ff @(posedge clk_g) begin
		if (tlb_rd_i)
			rd_way_q <= tlb_way_i;
		if (rd_q)
			tlb_rdata_o <= a_dout[rd_way_q];   // pick the requested way
	end

endmodule

/* sim/tlb_assert.sv */
`timescale 1ns/1ps

module tlb_assert (
	input logic        clk_g,
	input logic        rst_i,
	input logic        rdy_i,
	input logic        acc_i,
	input logic        done_i,
	input logic        miss_i,
	input logic [31:0] padr_i,
	input logic        tlb_wr_i,
	input logic        tlb_rd_i
);

	int fail_cnt = 0;   // failed assertions so far

	// ==================================================
	// access port
	// ==================================================
	// accesses wait for the boot fill
	a_acc_rdy: assert property (@(posedge clk_g) disable iff (rst_i)
		acc_i |-> rdy_i)
		else begin
			$error("access strobe while the tlb is not ready");
			fail_cnt++;
		end

	a_done_lat: assert property (@(posedge clk_g) disable iff (rst_i)
		acc_i |-> ##2 done_i)   // fixed two-stage pipe
		else begin
			$error("done_o missing two cycles after an access");
			fail_cnt++;
		end

	a_done_src: assert property (@(posedge clk_g) disable iff (rst_i)
		done_i |-> $past(acc_i, 2))
		else begin
			$error("done_o without an access two cycles earlier");
			fail_cnt++;
		end

	a_miss_padr: assert property (@(posedge clk_g) disable iff (rst_i)
		miss_i |-> (padr_i == 32'h0))
		else begin
			$error("miss_o with a nonzero physical address");
			fail_cnt++;
		end

	// software port only when port A is free of write-back
	a_sw_idle: assert property (@(posedge clk_g) disable iff (rst_i)
		(tlb_wr_i || tlb_rd_i) |-> !(acc_i || $past(acc_i) || $past(acc_i, 2)))
		else begin
			$error("software entry access while a lookup is in flight");
			fail_cnt++;
		end

endmodule

/* sim/tlb_tb.sv */
`timescale 1ns/1ps
`include "tlb_defs.svh"

module tlb_tb;
	import tlb_pkg::*;

	localparam int WAY_W       = $clog2(`TLB_WAYS);
	localparam int LAST        = `TLB_WAYS - 1;
	localparam int WAIT_LIMIT  = 16;    // cycles for one strobe to come back
	localparam int TEST_CYCLES = 500;   // all tests together, about 4 cycles per operation
	localparam int CYCLE_LIMIT = 10 * TEST_CYCLES + `TLB_SETS;
	localparam logic [19:0] BOOT_VPN = `TLB_BOOT_VPN;

	logic                  clk_g;
	logic                  rst;
	logic                  rdy;
	logic                  acc;
	logic [31:0]           vadr;
	acc_kind_t             kind;
	logic                  done;
	logic [31:0]           padr;
	logic [3:0]            acr;
	logic                  miss;
	logic [31:0]           miss_adr;
	logic                  tlb_wr;
	logic                  tlb_rd;
	logic [`TLB_IDX_W-1:0] tlb_idx;
	logic [WAY_W-1:0]      tlb_way;
	logic                  tlb_rand;
	tlb_entry_t            tlb_wdata;
	tlb_entry_t            tlb_rdata;
	logic                  rd_done;
	logic                  reg_we;
	reg_sel_t              reg_sel;
	logic [7:0]            reg_wdata;

	logic [31:0] rng = 32'hcaf5ab40;
	int          cycles = 0;
	int          errors = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	tlb_top DUT (
		.clk_g(clk_g), .rst_i(rst), .rdy_o(rdy),
		.acc_i(acc), .vadr_i(vadr), .kind_i(kind), .done_o(done), .padr_o(padr),
		.acr_o(acr), .miss_o(miss), .miss_adr_o(miss_adr),
		.tlb_wr_i(tlb_wr), .tlb_rd_i(tlb_rd), .tlb_idx_i(tlb_idx), .tlb_way_i(tlb_way),
		.tlb_rand_i(tlb_rand), .tlb_wdata_i(tlb_wdata), .tlb_rdata_o(tlb_rdata),
		.rd_done_o(rd_done),
		.reg_we_i(reg_we), .reg_sel_i(reg_sel), .reg_wdata_i(reg_wdata)
	);

	bind tlb_top tlb_assert u_assert (
		.clk_g(clk_g), .rst_i(rst_i), .rdy_i(rdy_o), .acc_i(acc_i), .done_i(done_o),
		.miss_i(miss_o), .padr_i(padr_o), .tlb_wr_i(tlb_wr_i), .tlb_rd_i(tlb_rd_i)
	);

	initial begin
		clk_g = 1'b0;
		forever #10 clk_g = ~clk_g;   // 20 ns period
	end

	// watchdog
	always @(posedge clk_g) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ==================================================
	// helpers
	// ==================================================
	task automatic tick();
		@(posedge clk_g);
		#2;   // drive and sample away from the edge
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// random vpn at a given set, top bit clear so never a boot page
	function automatic logic [19:0] make_vpn(input logic [`TLB_IDX_W-1:0] idx);
		logic [31:0] r;
		r = next_rand();
		return {1'b0, r[18:`TLB_IDX_W], idx};
	endfunction

	function automatic tlb_entry_t make_entry(input logic v, input logic g,
			input logic [7:0] asid, input logic [19:0] vpn, input logic [19:0] ppn,
			input logic a, input logic d, input logic [3:0] urt, input logic [3:0] srt);
		tlb_entry_t e;
		e      = '0;
		e.v    = v;
		e.g    = g;
		e.asid = asid;
		e.vpn  = vpn;
		e.ppn  = ppn;
		e.a    = a;
		e.d    = d;
		{e.c, e.r, e.w, e.x}     = urt;
		{e.sc, e.sr, e.sw, e.sx} = srt;
		return e;
	endfunction

	task automatic note_fail(input string msg);
		$display("error: %s", msg);
		errors++;
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic check_padr(input string sig, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", sig, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_acr(input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			$display("mismatch acr_o: got %h expected %h", got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_miss(input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch miss_o: got %h expected %h", got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_entry(input tlb_entry_t got, input tlb_entry_t exp);
		if (got !== exp) begin
			$display("mismatch tlb_rdata_o: got %h expected %h", got, exp);
			errors++;
			test_errs++;
		end
	endtask

	// ==================================================
	// port drivers
	// ==================================================
	task automatic set_reg(input reg_sel_t sel, input logic [7:0] val);
		reg_we    = 1'b1;
		reg_sel   = sel;
		reg_wdata = val;
		tick();
		reg_we = 1'b0;
	endtask

	task automatic write_entry(input logic [`TLB_IDX_W-1:0] idx, input int way,
			input logic rnd, input tlb_entry_t ent);
		tlb_wr    = 1'b1;
		tlb_idx   = idx;
		tlb_way   = WAY_W'(way);
		tlb_rand  = rnd;
		tlb_wdata = ent;
		tick();   // lands on this edge
		tlb_wr   = 1'b0;
		tlb_rand = 1'b0;
	endtask

	task automatic read_entry(input logic [`TLB_IDX_W-1:0] idx, input int way,
			output tlb_entry_t ent);
		int n;
		n       = 0;
		tlb_rd  = 1'b1;
		tlb_idx = idx;
		tlb_way = WAY_W'(way);
		tick();
		tlb_rd = 1'b0;
		while (!rd_done && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		ent = tlb_rdata;
		if (!rd_done)
			note_fail("rd_done_o never came back after a read");
	endtask

	// one access, then one more cycle so the a/d write-back is done
	task automatic lookup(input logic [31:0] va, input acc_kind_t k,
			input logic [31:0] exp_padr, input logic [3:0] exp_acr, input logic exp_miss);
		int n;
		n    = 0;
		acc  = 1'b1;
		vadr = va;
		kind = k;
		tick();
		acc = 1'b0;
		while (!done && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!done) begin
			note_fail("done_o never came back after an access");
		end else begin
			check_padr("padr_o", padr, exp_padr);
			check_acr(acr, exp_acr);
			check_miss(miss, exp_miss);
			if (exp_miss)
				check_padr("miss_adr_o", miss_adr, va);   // faulting address
		end
		tick();
	endtask

	// ==================================================
	// tests
	// ==================================================
	task automatic test_fill();
		int n;
		n = 0;
		check_padr("padr_o", padr, 32'h0);   // outputs quiet out of reset
		check_acr(acr, 4'h0);
		check_miss(miss, 1'b0);
		while (!rdy && n < `TLB_SETS + WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!rdy)
			note_fail("rdy_o did not rise after the boot fill");
		finish_test("reset and fill");
	endtask

	task automatic test_boot();
		logic [31:0] va;
		logic [19:0] vpn;
		set_reg(REG_ASID, 8'h00);
		for (int m = 0; m < 2; m++) begin
			set_reg(REG_MODE, m ? 8'h03 : 8'h02);   // xlat on, user then sys
			for (int i = 0; i < `TLB_BOOT_PAGES; i++) begin
				va = {BOOT_VPN + 20'(i), 12'(next_rand())};
				lookup(va, ACC_LOAD, va, 4'hF, 1'b0);   // identity map
			end
		end
		vpn = make_vpn(6'h2a);
		va  = {vpn, 12'h5c4};
		lookup(va, ACC_LOAD, 32'h0, 4'h0, 1'b1);
		finish_test("boot mapping");
	endtask

	task automatic test_passthru();
		logic [31:0] va;
		set_reg(REG_MODE, 8'h00);
		for (int i = 0; i < 8; i++) begin
			va = next_rand();
			lookup(va, (i % 2) ? ACC_STORE : ACC_FETCH, va, 4'hF, 1'b0);
		end
		set_reg(REG_MODE, 8'h02);
		finish_test("translation off");
	endtask

	task automatic test_asid();
		tlb_entry_t  e;
		logic [19:0] vpn;
		logic [19:0] ppn;
		logic [31:0] va;
		vpn = make_vpn(6'h01);
		ppn = 20'(next_rand());
		va  = {vpn, 12'h0a8};
		e   = make_entry(1'b1, 1'b0, 8'h05, vpn, ppn, 1'b0, 1'b0, 4'b0111, 4'hF);
		write_entry(6'h01, 1, 1'b0, e);
		set_reg(REG_ASID, 8'h05);
		lookup(va, ACC_LOAD, {ppn, va[11:0]}, 4'b0111, 1'b0);
		set_reg(REG_ASID, 8'h06);
		lookup(va, ACC_LOAD, 32'h0, 4'h0, 1'b1);   // other address space
		e.g = 1'b1;
		write_entry(6'h01, 1, 1'b0, e);
		lookup(va, ACC_LOAD, {ppn, va[11:0]}, 4'b0111, 1'b0);
		set_reg(REG_ASID, 8'h05);
		lookup(va, ACC_LOAD, {ppn, va[11:0]}, 4'b0111, 1'b0);
		finish_test("asid and global");
	endtask

	task automatic test_rights();
		tlb_entry_t  e;
		logic [19:0] vpn;
		logic [31:0] va;
		vpn = make_vpn(6'h02);
		va  = {vpn, 12'hffc};
		e   = make_entry(1'b1, 1'b1, 8'h00, vpn, vpn ^ 20'h12345, 1'b1, 1'b1, 4'b0101, 4'b1010);
		write_entry(6'h02, 0, 1'b0, e);
		set_reg(REG_MODE, 8'h03);
		lookup(va, ACC_FETCH, {vpn ^ 20'h12345, va[11:0]}, 4'b1010, 1'b0);
		set_reg(REG_MODE, 8'h02);
		lookup(va, ACC_FETCH, {vpn ^ 20'h12345, va[11:0]}, 4'b0101, 1'b0);
		finish_test("user and system rights");
	endtask

	task automatic test_acc_dirty();
		tlb_entry_t  e;
		tlb_entry_t  got;
		logic [19:0] vpn;
		logic [31:0] va;
		vpn = make_vpn(6'h03);
		va  = {vpn, 12'h010};
		e   = make_entry(1'b1, 1'b1, 8'h00, vpn, vpn, 1'b0, 1'b0, 4'hF, 4'hF);
		write_entry(6'h03, 2, 1'b0, e);
		lookup(va, ACC_LOAD, va, 4'hF, 1'b0);
		read_entry(6'h03, 2, got);
		e.a = 1'b1;   // load marks accessed only
		check_entry(got, e);
		lookup(va, ACC_STORE, va, 4'hF, 1'b0);
		read_entry(6'h03, 2, got);
		e.d = 1'b1;
		check_entry(got, e);
		finish_test("accessed and dirty");
	endtask

	task automatic test_random_write();
		logic [19:0] vpns [8];
		logic [19:0] ppns [8];
		tlb_entry_t  got;
		tlb_entry_t  exp;
		int          found;
		logic [19:0] bvpn;
		for (int k = 0; k < 8; k++) begin
			vpns[k] = make_vpn(6'h10 + 6'(k));   // distinct sets
			ppns[k] = 20'(next_rand());
			exp = make_entry(1'b1, 1'b1, 8'h00, vpns[k], ppns[k], 1'b0, 1'b0, 4'hF, 4'hF);
			write_entry(6'h10 + 6'(k), LAST, 1'b1, exp);   // way input ignored
		end
		for (int k = 0; k < 8; k++)
			lookup({vpns[k], 12'h123}, ACC_LOAD, {ppns[k], 12'h123}, 4'hF, 1'b0);
		for (int k = 0; k < 8; k++) begin
			found = -1;
			exp = make_entry(1'b1, 1'b1, 8'h00, vpns[k], ppns[k], 1'b1, 1'b0, 4'hF, 4'hF);
			for (int w = 0; w < `TLB_WAYS; w++) begin
				read_entry(6'h10 + 6'(k), w, got);
				if (got.v && got.vpn == vpns[k]) begin
					found = w;
					check_entry(got, exp);
				end
			end
			if (found < 0)
				note_fail($sformatf("page %h not found in any way", vpns[k]));
			else if (found == LAST)
				note_fail($sformatf("page %h was written to the last way", vpns[k]));
		end
		// boot entries still in place
		for (int i = 0; i < `TLB_BOOT_PAGES; i++) begin
			bvpn = BOOT_VPN + 20'(i);
			read_entry(bvpn[`TLB_IDX_W-1:0], LAST, got);
			check_entry(got, make_entry(1'b1, 1'b1, 8'h00, bvpn, bvpn, 1'b1, 1'b1, 4'hF, 4'hF));
		end
		finish_test("random victim writes");
	endtask

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		rst       = 1'b1;
		acc       = 1'b0;
		vadr      = 32'h0;
		kind      = ACC_LOAD;
		tlb_wr    = 1'b0;
		tlb_rd    = 1'b0;
		tlb_idx   = '0;
		tlb_way   = '0;
		tlb_rand  = 1'b0;
		tlb_wdata = '0;
		reg_we    = 1'b0;
		reg_sel   = REG_ASID;
		reg_wdata = 8'h00;
		repeat (3) @(posedge clk_g);
		#2;
		rst = 1'b0;
		test_fill();
		if (rdy) begin
			test_boot();
			test_passthru();
			test_asid();
			test_rights();
			test_acc_dirty();
			test_random_write();
		end
		errors += DUT.u_assert.fail_cnt;   // bound checker failures
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+include
source/tlb_pkg.sv
source/tlb_way_ram.sv
source/tlb_boot_fill.sv
source/tlb_ctrl_regs.sv
source/tlb_lookup.sv
source/tlb_top.sv
sim/tlb_assert.sv
sim/tlb_tb.sv

/* Bender.yml */
package:
  name: tlb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/tlb_pkg.sv
      - source/tlb_way_ram.sv
      - source/tlb_boot_fill.sv
      - source/tlb_ctrl_regs.sv
      - source/tlb_lookup.sv
      - source/tlb_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tlb_assert.sv
      - sim/tlb_tb.sv
